// ==== logic/bidi_message_queue.sv ====
////////////////////
// Bidirectional message queue
// Host and device endpoints sharing one SRAM through an arbiter.
////////////////////
`default_nettype none

module bidi_message_queue
	import msgq_pkg::*;
#(
	parameter int RING_ADDR_BITS = RING_ADDR_BITS_DEFAULT
) (
	input  wire logic      clk,
	input  wire logic      rst,
	// Host side.
	input  wire logic      host_push,
	input  wire msg_word_t host_push_data,
	input  wire logic      host_pop,
	output msg_word_t      host_pop_data,
	output logic           host_pop_valid,
	output logic           host_busy,
	output logic           host_full,
	output logic           host_empty,
	output logic           irq,
	// Device side.
	input  wire logic      dev_push,
	input  wire msg_word_t dev_push_data,
	input  wire logic      dev_pop,
	output msg_word_t      dev_pop_data,
	output logic           dev_pop_valid,
	output logic           dev_busy,
	output logic           dev_full,
	output logic           dev_empty
);

	localparam int ADDR_BITS = RING_ADDR_BITS + 1;

	// Pointer exchange.
	logic [RING_ADDR_BITS:0] host_tx_wr_ptr;
	logic [RING_ADDR_BITS:0] host_rx_rd_ptr;
	logic [RING_ADDR_BITS:0] dev_tx_wr_ptr;
	logic [RING_ADDR_BITS:0] dev_rx_rd_ptr;

	// Endpoint to arbiter.
	logic                 host_req;
	logic                 host_we;
	logic                 host_gnt;
	logic [ADDR_BITS-1:0] host_addr;
	msg_word_t            host_wdata;
	logic                 dev_req;
	logic                 dev_we;
	logic                 dev_gnt;
	logic [ADDR_BITS-1:0] dev_addr;
	msg_word_t            dev_wdata;

	// SRAM port.
	logic                 mem_en;
	logic                 mem_we;
	logic [ADDR_BITS-1:0] mem_addr;
	msg_word_t            mem_wdata;
	msg_word_t            mem_rdata;

	queue_endpoint #(
		.RING_ADDR_BITS (RING_ADDR_BITS),
		.TX_RING        (1'b0)
	) u_host (
		.clk         (clk),
		.rst         (rst),
		.push        (host_push),
		.push_data   (host_push_data),
		.pop         (host_pop),
		.peer_wr_ptr (dev_tx_wr_ptr),
		.peer_rd_ptr (dev_rx_rd_ptr),
		.gnt         (host_gnt),
		.rdata       (mem_rdata),
		.pop_data    (host_pop_data),
		.pop_valid   (host_pop_valid),
		.busy        (host_busy),
		.full        (host_full),
		.empty       (host_empty),
		.irq         (irq),
		.tx_wr_ptr   (host_tx_wr_ptr),
		.rx_rd_ptr   (host_rx_rd_ptr),
		.req         (host_req),
		.we          (host_we),
		.addr        (host_addr),
		.wdata       (host_wdata)
	);

	queue_endpoint #(
		.RING_ADDR_BITS (RING_ADDR_BITS),
		.TX_RING        (1'b1)
	) u_dev (
		.clk         (clk),
		.rst         (rst),
		.push        (dev_push),
		.push_data   (dev_push_data),
		.pop         (dev_pop),
		.peer_wr_ptr (host_tx_wr_ptr),
		.peer_rd_ptr (host_rx_rd_ptr),
		.gnt         (dev_gnt),
		.rdata       (mem_rdata),
		.pop_data    (dev_pop_data),
		.pop_valid   (dev_pop_valid),
		.busy        (dev_busy),
		.full        (dev_full),
		.empty       (dev_empty),
		.irq         (),
		.tx_wr_ptr   (dev_tx_wr_ptr),
		.rx_rd_ptr   (dev_rx_rd_ptr),
		.req         (dev_req),
		.we          (dev_we),
		.addr        (dev_addr),
		.wdata       (dev_wdata)
	);

	sram_arbiter #(
		.ADDR_BITS (ADDR_BITS)
	) u_arb (
		.clk        (clk),
		.rst        (rst),
		.host_req   (host_req),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.dev_req    (dev_req),
		.dev_we     (dev_we),
		.dev_addr   (dev_addr),
		.dev_wdata  (dev_wdata),
		.host_gnt   (host_gnt),
		.dev_gnt    (dev_gnt),
		.mem_en     (mem_en),
		.mem_we     (mem_we),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata)
	);

	msg_sram #(
		.ADDR_BITS (ADDR_BITS)
	) u_mem (
		.clk   (clk),
		.en    (mem_en),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

endmodule

`default_nettype wire

// ==== logic/msg_sram.sv ====
////////////////////
// Message SRAM
// Single-port synchronous RAM holding both rings.
////////////////////
`default_nettype none

module msg_sram
	import msgq_pkg::*;
#(
	parameter int ADDR_BITS = $bits(sram_addr_t)
) (
	input  wire logic                 clk,
	input  wire logic                 en,
	input  wire logic                 we,
	input  wire logic [ADDR_BITS-1:0] addr,
	input  wire msg_word_t            wdata,
	output msg_word_t                 rdata
);

	localparam int DEPTH = 2 ** ADDR_BITS;

	msg_word_t mem [DEPTH]; // Lower half host-to-device, upper half device-to-host.

	// Read data is registered and only changes on a read access.
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata; // Write leaves rdata unchanged.
			end else begin
				rdata <= mem[addr]; // Valid on the next cycle.
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/msgq_pkg.sv ====
////////////////////
// Message queue package
// Word, address and pointer types shared by the queue endpoints,
// the SRAM arbiter and the testbench.
////////////////////
`default_nettype none

package msgq_pkg;

	////////////////////
	// Widths
	////////////////////

	// Log2 of the ring depth. Eight words per ring.
	localparam int RING_ADDR_BITS_DEFAULT = 3;

	////////////////////
	// Types
	////////////////////

	// One message word.
	typedef logic [31:0] msg_word_t;

	// SRAM word address. The top bit selects the ring.
	typedef logic [RING_ADDR_BITS_DEFAULT:0] sram_addr_t;

	// Ring index plus wrap bit.
	// Equal pointers mean empty, differing only in the wrap bit means full.
	typedef logic [RING_ADDR_BITS_DEFAULT:0] ring_ptr_t;

	// Endpoint that was granted last.
	typedef enum logic {
		owner_host = 1'b0,
		owner_dev  = 1'b1
	} arb_owner_e;

endpackage

`default_nettype wire

// ==== logic/queue_endpoint.sv ====
////////////////////
// Queue endpoint
// One side of the message queue. Pushes into the outgoing ring,
// pops from the incoming ring and raises irq on new messages.
////////////////////
`default_nettype none

module queue_endpoint
	import msgq_pkg::*;
#(
	parameter int RING_ADDR_BITS = RING_ADDR_BITS_DEFAULT,
	parameter bit TX_RING        = 1'b0
) (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire logic                    push,
	input  wire msg_word_t               push_data,
	input  wire logic                    pop,
	input  wire logic [RING_ADDR_BITS:0] peer_wr_ptr,
	input  wire logic [RING_ADDR_BITS:0] peer_rd_ptr,
	input  wire logic                    gnt,
	input  wire msg_word_t               rdata,
	output msg_word_t                    pop_data,
	output logic                         pop_valid,
	output logic                         busy,
	output logic                         full,
	output logic                         empty,
	output logic                         irq,
	output logic [RING_ADDR_BITS:0]      tx_wr_ptr,
	output logic [RING_ADDR_BITS:0]      rx_rd_ptr,
	output logic                         req,
	output logic                         we,
	output logic [RING_ADDR_BITS:0]      addr,
	output msg_word_t                    wdata
);

	typedef enum logic [1:0] {
		st_idle,
		st_wait_grant,
		st_wait_data
	} ep_state_e;

	ep_state_e state;
	logic      op_push;    // Latched operation, push or pop.
	msg_word_t push_q;     // Word waiting to be written.
	logic      rx_empty_q; // Incoming ring empty, one cycle late.

	////////////////////
	// Ring flags
	////////////////////

	assign full = (tx_wr_ptr[RING_ADDR_BITS] != peer_rd_ptr[RING_ADDR_BITS]) &&
		(tx_wr_ptr[RING_ADDR_BITS-1:0] == peer_rd_ptr[RING_ADDR_BITS-1:0]);
	assign empty = (rx_rd_ptr == peer_wr_ptr);
	assign busy  = (state != st_idle);

	////////////////////
	// SRAM request
	////////////////////

	assign req   = (state == st_wait_grant);
	assign we    = op_push;
	assign wdata = push_q;

	// Ring select bit on top of the pointer index.
	assign addr = op_push ? {TX_RING, tx_wr_ptr[RING_ADDR_BITS-1:0]} :
		{~TX_RING, rx_rd_ptr[RING_ADDR_BITS-1:0]};

	////////////////////
	// Control FSM
	////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= st_idle;
			op_push   <= 1'b0;
			tx_wr_ptr <= '0;
			rx_rd_ptr <= '0;
			pop_valid <= 1'b0;
		end else begin
			pop_valid <= 1'b0;
			case (state)
				st_idle: begin
					if (push && !full) begin
						op_push <= 1'b1;
						state   <= st_wait_grant;
					end else if (pop && !empty) begin
						op_push <= 1'b0;
						state   <= st_wait_grant;
					end
				end
				st_wait_grant: begin
					if (gnt) begin
						if (op_push) begin
							tx_wr_ptr <= tx_wr_ptr + 1'b1; // Word written at this edge.
							state     <= st_idle;
						end else begin
							rx_rd_ptr <= rx_rd_ptr + 1'b1;
							state     <= st_wait_data;
						end
					end
				end
				st_wait_data: begin
					pop_valid <= 1'b1; // Busy falls with it.
					state     <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Payload registers.
	always_ff @(posedge clk) begin
		if (state == st_idle && push) begin
			push_q <= push_data;
		end
		if (state == st_wait_data) begin
			pop_data <= rdata; // SRAM data for our read.
		end
	end

	// New message interrupt. A granted pop takes priority.
	always_ff @(posedge clk) begin
		if (rst) begin
			irq        <= 1'b0;
			rx_empty_q <= 1'b1;
		end else begin
			rx_empty_q <= empty;
			if (req && gnt && !op_push) begin
				irq <= 1'b0;
			end else if (rx_empty_q && !empty) begin
				irq <= 1'b1;
			end
		end
	end

	////////////////////
	// Checks
	////////////////////

	a_push_legal: assert property (@(posedge clk) disable iff (rst)
		push |-> !busy && !full);

	a_pop_legal: assert property (@(posedge clk) disable iff (rst)
		pop |-> !busy && !empty);

endmodule

`default_nettype wire

// ==== logic/sram_arbiter.sv ====
////////////////////
// SRAM arbiter
// Round-robin choice between the host and device endpoints,
// steering the granted access onto the SRAM port.
////////////////////
`default_nettype none

module sram_arbiter
	import msgq_pkg::*;
#(
	parameter int ADDR_BITS = $bits(sram_addr_t)
) (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 host_req,
	input  wire logic                 host_we,
	input  wire logic [ADDR_BITS-1:0] host_addr,
	input  wire msg_word_t            host_wdata,
	input  wire logic                 dev_req,
	input  wire logic                 dev_we,
	input  wire logic [ADDR_BITS-1:0] dev_addr,
	input  wire msg_word_t            dev_wdata,
	output logic                      host_gnt,
	output logic                      dev_gnt,
	output logic                      mem_en,
	output logic                      mem_we,
	output logic [ADDR_BITS-1:0]      mem_addr,
	output msg_word_t                 mem_wdata
);

	arb_owner_e last_owner;

	// On a tie the endpoint not granted last wins.
	assign host_gnt = host_req && (!dev_req || last_owner == owner_dev);
	assign dev_gnt  = dev_req && (!host_req || last_owner == owner_host);

	// Access steering.
	assign mem_en    = host_gnt || dev_gnt;
	assign mem_we    = host_gnt ? host_we    : dev_we;
	assign mem_addr  = host_gnt ? host_addr  : dev_addr;
	assign mem_wdata = host_gnt ? host_wdata : dev_wdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			last_owner <= owner_dev; // Host wins the first tie.
		end else if (host_gnt) begin
			last_owner <= owner_host;
		end else if (dev_gnt) begin
			last_owner <= owner_dev;
		end
	end

	////////////////////
	// Checks
	////////////////////

	// A requester waits for at most one access of the other side.
	a_host_wait: assert property (@(posedge clk) disable iff (rst)
		host_req && !host_gnt |=> host_gnt);

	a_dev_wait: assert property (@(posedge clk) disable iff (rst)
		dev_req && !dev_gnt |=> dev_gnt);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the message queue testbench with Verilator and run it.
# Exits non-zero when the build fails, the simulator fails or the log reports failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module bidi_message_queue_tb \
	-f src.f \
	-o bidi_message_queue_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/bidi_message_queue_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
	echo "Simulation reported failure, see $LOG"
	exit 1
fi

echo "Simulation finished without failure"
exit 0

// ==== src.f ====
logic/msgq_pkg.sv
logic/msg_sram.sv
logic/sram_arbiter.sv
logic/queue_endpoint.sv
logic/bidi_message_queue.sv
tb/bidi_message_queue_tb.sv

// ==== tb/bidi_message_queue_tb.sv ====
////////////////////
// Message queue testbench
// Table-driven and random traffic through both rings,
// checked against a queue model per ring.
////////////////////
`default_nettype none

module bidi_message_queue_tb
	import msgq_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ns;

	localparam int   DEPTH        = 2 ** RING_ADDR_BITS_DEFAULT;
	localparam int   RAND_OPS     = 24; // Random operations per side.
	localparam int   RESET_CYCLES = 16;
	localparam logic OP_PUSH      = 1'b0;
	localparam logic OP_POP       = 1'b1;

	typedef struct packed {
		logic [2:0] test;
		logic       side; // 0 host, 1 device.
		logic       op;
		msg_word_t  data;
		msg_word_t  expect_word;
	} op_entry_t;

	logic       clk;
	logic       rst;
	logic [1:0] push_s, pop_s, busy_s, full_s, empty_s, valid_s;
	logic       irq;
	msg_word_t  push_data_s [2];
	msg_word_t  pop_data_s [2];

	op_entry_t   table_q [$];
	msg_word_t   ring_q [2][$]; // Ring 0 host-to-device, ring 1 device-to-host.
	logic        irq_exp;
	logic [15:0] lfsr_state;
	logic        rnd_push [2][RAND_OPS];
	msg_word_t   rnd_data [2][RAND_OPS];
	int          push_cnt [2];
	int          pop_cnt [2];
	int          errors, errors_mark, tests_run, tests_failed;
	int          cycles, limit;

	bidi_message_queue #(
		.RING_ADDR_BITS (RING_ADDR_BITS_DEFAULT)
	) bidi_message_queue_inst (
		.clk (clk), .rst (rst),
		.host_push (push_s[0]), .host_push_data (push_data_s[0]), .host_pop (pop_s[0]),
		.host_pop_data (pop_data_s[0]), .host_pop_valid (valid_s[0]),
		.host_busy (busy_s[0]), .host_full (full_s[0]), .host_empty (empty_s[0]),
		.irq (irq),
		.dev_push (push_s[1]), .dev_push_data (push_data_s[1]), .dev_pop (pop_s[1]),
		.dev_pop_data (pop_data_s[1]), .dev_pop_valid (valid_s[1]),
		.dev_busy (busy_s[1]), .dev_full (full_s[1]), .dev_empty (empty_s[1])
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// Run limit.
	always @(posedge clk) begin
		cycles++;
		if (cycles >= limit) begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// Pop_valid pulses seen on each side.
	always @(negedge clk) begin
		for (int s = 0; s < 2; s++) begin
			if (valid_s[s]) pop_cnt[s]++;
		end
	end

	function automatic string side_name(input int side);
		return (side != 0) ? "dev" : "host";
	endfunction

	// Galois LFSR, one step per bit taken.
	function automatic msg_word_t random_bits(input int n);
		msg_word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
		end
		return v;
	endfunction

	task automatic report_error(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != errors_mark) begin
			tests_failed++;
		end
		$display("Test %0d %s: %s", tests_run, name, (errors == errors_mark) ? "ok" : "failed");
		errors_mark = errors;
	endtask

	task automatic check_flags(input bit check_irq);
		for (int s = 0; s < 2; s++) begin
			if (busy_s[s]) report_error($sformatf("%s busy high while idle", side_name(s)));
			if (full_s[s] != (ring_q[s].size() == DEPTH)) begin
				report_error($sformatf("%s full is %0b, model holds %0d words",
					side_name(s), full_s[s], ring_q[s].size()));
			end
			if (empty_s[s] != (ring_q[s ^ 1].size() == 0)) begin
				report_error($sformatf("%s empty is %0b, model holds %0d words",
					side_name(s), empty_s[s], ring_q[s ^ 1].size()));
			end
		end
		if (check_irq && irq != irq_exp) begin
			report_error($sformatf("irq is %0b, expected %0b", irq, irq_exp));
		end
	endtask

	task automatic push_word(input int side, input msg_word_t data);
		while (busy_s[side]) @(negedge clk);
		if (side == 1 && ring_q[1].size() == 0) irq_exp = 1'b1; // Empty to non-empty.
		ring_q[side].push_back(data);
		push_s[side] = 1'b1;
		push_data_s[side] = data;
		@(negedge clk);
		push_s[side] = 1'b0;
		@(negedge clk);
		while (busy_s[side]) @(negedge clk);
		push_cnt[side]++;
		@(negedge clk); // Idle cycle, lets irq follow.
	endtask

	task automatic pop_word(input int side, output msg_word_t word);
		while (busy_s[side]) @(negedge clk);
		pop_s[side] = 1'b1;
		@(negedge clk);
		pop_s[side] = 1'b0;
		while (!valid_s[side]) @(negedge clk);
		word = pop_data_s[side];
		if (busy_s[side]) report_error($sformatf("%s busy high with pop_valid", side_name(side)));
		@(negedge clk);
		if (valid_s[side]) report_error($sformatf("%s pop_valid longer than one cycle", side_name(side)));
		if (side == 0) irq_exp = 1'b0;
	endtask

	// Popped word against the head of the model ring.
	task automatic compare_model(input int side, input msg_word_t word);
		msg_word_t exp_word;
		if (ring_q[side ^ 1].size() == 0) begin
			report_error($sformatf("%s popped %h from an empty model ring", side_name(side), word));
		end else begin
			exp_word = ring_q[side ^ 1].pop_front();
			if (word !== exp_word) begin
				report_error($sformatf("%s popped %h, model expects %h", side_name(side), word, exp_word));
			end
		end
	endtask

	task automatic run_traffic(input int side);
		msg_word_t word;
		for (int i = 0; i < RAND_OPS; i++) begin
			if (!full_s[side] && (rnd_push[side][i] || empty_s[side])) begin
				push_word(side, rnd_data[side][i]);
			end else if (!empty_s[side]) begin
				pop_word(side, word);
				compare_model(side, word);
			end else begin
				@(negedge clk);
			end
		end
	endtask

	initial begin
		op_entry_t  entry;
		msg_word_t  word;
		arb_owner_e owner;
		string      names [5];

		names = '{"", "reset state", "host-to-device order", "device-to-host irq", "full ring"};
		table_q.push_back('{3'd2, 1'b0, OP_PUSH, 32'h1111_0001, 32'h0});
		table_q.push_back('{3'd2, 1'b0, OP_PUSH, 32'h2222_0002, 32'h0});
		table_q.push_back('{3'd2, 1'b0, OP_PUSH, 32'h3333_0003, 32'h0});
		table_q.push_back('{3'd2, 1'b1, OP_POP,  32'h0, 32'h1111_0001});
		table_q.push_back('{3'd2, 1'b1, OP_POP,  32'h0, 32'h2222_0002});
		table_q.push_back('{3'd2, 1'b1, OP_POP,  32'h0, 32'h3333_0003});
		table_q.push_back('{3'd3, 1'b1, OP_PUSH, 32'hC0DE_0001, 32'h0});
		table_q.push_back('{3'd3, 1'b0, OP_POP,  32'h0, 32'hC0DE_0001});
		table_q.push_back('{3'd3, 1'b1, OP_PUSH, 32'hC0DE_0002, 32'h0});
		table_q.push_back('{3'd3, 1'b1, OP_PUSH, 32'hC0DE_0003, 32'h0});
		table_q.push_back('{3'd3, 1'b0, OP_POP,  32'h0, 32'hC0DE_0002});
		table_q.push_back('{3'd3, 1'b0, OP_POP,  32'h0, 32'hC0DE_0003});
		for (int i = 0; i < DEPTH; i++) table_q.push_back('{3'd4, 1'b0, OP_PUSH, 32'hA5A5_0000 + i, 32'h0});
		for (int i = 0; i < DEPTH; i++) table_q.push_back('{3'd4, 1'b1, OP_POP, 32'h0, 32'hA5A5_0000 + i});
		limit = 8 * (table_q.size() + 2 * RAND_OPS) + RESET_CYCLES;

		rst = 1'b1;
		push_s = '0;
		pop_s = '0;
		push_data_s = '{32'h0, 32'h0};
		irq_exp = 1'b0;
		lfsr_state = 16'd16943;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		check_flags(1'b1);
		if (valid_s != 2'b00) report_error("pop_valid high after reset");
		finish_test(names[1]);

		////////////////////
		// Table phase
		////////////////////
		for (int i = 0; i < table_q.size(); i++) begin
			entry = table_q[i];
			check_flags(1'b1);
			if (entry.op == OP_PUSH) begin
				push_word(int'(entry.side), entry.data);
			end else begin
				pop_word(int'(entry.side), word);
				compare_model(int'(entry.side), word);
				if (word !== entry.expect_word) begin
					report_error($sformatf("entry %0d popped %h, expected %h", i, word, entry.expect_word));
				end
			end
			if (i == table_q.size() - 1 || table_q[i + 1].test != entry.test) begin
				check_flags(1'b1);
				finish_test(names[entry.test]);
			end
		end

		////////////////////
		// Random phase
		////////////////////
		for (int i = 0; i < RAND_OPS; i++) begin
			for (int s = 0; s < 2; s++) begin
				rnd_push[s][i] = (random_bits(1) != 0);
				rnd_data[s][i] = random_bits(32);
			end
		end
		fork
			run_traffic(0);
			run_traffic(1);
		join
		for (int s = 0; s < 2; s++) begin // Drain what is left.
			while (ring_q[s ^ 1].size() > 0) begin
				pop_word(s, word);
				compare_model(s, word);
			end
		end
		for (int r = 0; r < 2; r++) begin
			if (pop_cnt[r ^ 1] != push_cnt[r]) begin
				report_error($sformatf("ring %0d: %0d pushes, %0d pops", r, push_cnt[r], pop_cnt[r ^ 1]));
			end
		end
		check_flags(1'b0);
		owner = bidi_message_queue_inst.u_arb.last_owner;
		$display("Arbiter last granted %s", owner.name());
		finish_test("concurrent traffic");

		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
